// File: vlog.f
+incdir+include
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/decoder.sv
verilog/pc_fetch.sv
verilog/cpu_top.sv
dv/cpu_top_sva.sv
dv/tb_cpu_top.sv

// File: Makefile
# Verilator flow for the RV64I core testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_cpu_top
RTL_TOP   ?= cpu_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)
	@echo "run passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_cpu_top.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_cpu_top;

  localparam logic [cpu_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_0000_1000;
  localparam int MEM_WORDS = 64;
  localparam int NUM_REGS = 2 ** cpu_pkg::REG_AW;
  localparam int WAIT_WINDOW = 16;
  // upper bound on fetched words over all tests
  localparam int MAX_INSTS = 32;
  // reset-to-halt runs
  localparam int NUM_RUNS = 6;
  // worst case word takes 6 cycles with 3 wait states
  // 8 per word leaves slack
  localparam int CYCLE_LIMIT = MAX_INSTS * 8 + NUM_RUNS * (8 + WAIT_WINDOW + 4) + 100;

  logic                       clk = 1'b0;
  logic                       rst_n = 1'b0;
  logic                       wb_ack = 1'b0;
  logic [cpu_pkg::INST_W-1:0] wb_dat_i = '0;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic [cpu_pkg::XLEN-1:0]   wb_adr;
  logic                       halted;
  logic                       illegal;
  logic                       commit_valid;
  logic [cpu_pkg::XLEN-1:0]   commit_pc;
  logic [cpu_pkg::REG_AW-1:0] commit_rd;
  logic [cpu_pkg::XLEN-1:0]   commit_wdata;

  // program image and reference state
  logic [cpu_pkg::INST_W-1:0] imem [MEM_WORDS];
  logic [cpu_pkg::XLEN-1:0]   ref_regs [NUM_REGS];
  logic [cpu_pkg::XLEN-1:0]   exp_pc [$];
  logic [cpu_pkg::REG_AW-1:0] exp_rd [$];
  logic [cpu_pkg::XLEN-1:0]   exp_val [$];
  logic [cpu_pkg::XLEN-1:0]   prog_pc;
  int                         prog_len;
  string                      cur_test = "none";
  int                         runs_done = 0;
  // bus slave state
  int                         seed = 75280;
  logic                       busy = 1'b0;
  int                         wait_left = 0;
  logic [cpu_pkg::XLEN-1:0]   exp_adr = RESET_PC;
  int                         req_count = 0;
  int                         cycles = 0;

  cpu_top #(
    .reset_pc (RESET_PC)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_ack       (wb_ack),
    .wb_dat_i     (wb_dat_i),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .halted       (halted),
    .illegal      (illegal),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_wdata (commit_wdata)
  );

  // 8 ns period
  initial begin
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic stop_with_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_now(input string msg);
    $display("%s: %s", cur_test, msg);
    stop_with_fail();
  endtask

  task automatic check_word(input string what, input logic [cpu_pkg::XLEN-1:0] exp_v,
                            input logic [cpu_pkg::XLEN-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Error: %s %s expected %h actual %h", cur_test, what, exp_v, act_v);
      stop_with_fail();
    end
  endtask

  task automatic check_reg(input string what, input logic [cpu_pkg::REG_AW-1:0] exp_v,
                           input logic [cpu_pkg::REG_AW-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Error: %s %s expected x%0d actual x%0d", cur_test, what, exp_v, act_v);
      stop_with_fail();
    end
  endtask

  task automatic check_flag(input string what, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Error: %s %s expected %b actual %b", cur_test, what, exp_v, act_v);
      stop_with_fail();
    end
  endtask

  // opcode 7f is unimplemented so a stray fetch halts as illegal
  function automatic logic [31:0] fill_word(input logic [cpu_pkg::XLEN-1:0] adr);
    logic [31:0] fold;
    fold = adr[63:32] ^ adr[31:0];
    return {fold[31:7] ^ {18'h0, fold[6:0]}, 7'h7F};
  endfunction

  function automatic logic [31:0] read_word(input logic [cpu_pkg::XLEN-1:0] adr);
    logic [cpu_pkg::XLEN-1:0] off;
    off = adr - RESET_PC;
    if (adr[1:0] == 2'b00 && off < 64'(MEM_WORDS * 4)) begin
      return imem[int'(off >> 2)];
    end
    return fill_word(adr);
  endfunction

  // wishbone classic slave with 0 to 3 wait states per transfer
  always @(posedge clk) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      busy      = 1'b0;
      exp_adr   = RESET_PC;
      req_count = 0;
    end else if (wb_ack) begin
      // master latched the word on this edge
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        // new request must follow the previous address by 4
        check_word("fetch address", exp_adr, wb_adr);
        exp_adr   = exp_adr + 64'd4;
        req_count = req_count + 1;
        busy      = 1'b1;
        wait_left = {$random(seed)} % 4;
      end
      if (wait_left == 0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= read_word(wb_adr);
        busy      = 1'b0;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, no end of test after %0d cycles", cycles);
      stop_with_fail();
    end
  end

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [4:0] rd);
    return {imm, rs1, `F3_ADD_SUB, rd, `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, `F3_ADD_SUB, rd, `OPC_OP};
  endfunction

  // u-type value with imm20 at bit 12 and the sign taken from bit 31
  function automatic logic [cpu_pkg::XLEN-1:0] upper(input logic [19:0] imm20);
    return {{32{imm20[19]}}, imm20, 12'h000};
  endfunction

  // hold reset while memory and reference state are cleared
  task automatic begin_run(input string name);
    cur_test = name;
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = fill_word(RESET_PC + 64'(i) * 64'd4);
    end
    for (int r = 0; r < NUM_REGS; r++) begin
      ref_regs[r] = '0;
    end
    exp_pc.delete();
    exp_rd.delete();
    exp_val.delete();
    prog_pc  = RESET_PC;
    prog_len = 0;
  endtask

  // retiring word plus its expected commit
  task automatic put_retiring(input logic [31:0] word, input logic [cpu_pkg::REG_AW-1:0] rd,
                              input logic [cpu_pkg::XLEN-1:0] val);
    imem[prog_len] = word;
    exp_pc.push_back(prog_pc);
    exp_rd.push_back(rd);
    exp_val.push_back(val);
    // x0 commits but keeps zero
    if (rd != '0) begin
      ref_regs[rd] = val;
    end
    prog_pc  = prog_pc + 64'd4;
    prog_len = prog_len + 1;
  endtask

  // ebreak, illegal or never-fetched word
  task automatic put_word(input logic [31:0] word);
    imem[prog_len] = word;
    prog_pc  = prog_pc + 64'd4;
    prog_len = prog_len + 1;
  endtask

  task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    put_retiring(enc_i(imm, rs1, rd), rd, ref_regs[rs1] + {{52{imm[11]}}, imm});
  endtask

  task automatic do_op(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                       input logic sub);
    logic [cpu_pkg::XLEN-1:0] val;
    logic [6:0]               f7;
    val = sub ? ref_regs[rs1] - ref_regs[rs2] : ref_regs[rs1] + ref_regs[rs2];
    f7  = sub ? `F7_SUB : 7'b0000000;
    put_retiring(enc_r(f7, rs2, rs1, rd), rd, val);
  endtask

  task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm20);
    put_retiring({imm20, rd, `OPC_LUI}, rd, upper(imm20));
  endtask

  task automatic do_auipc(input logic [4:0] rd, input logic [19:0] imm20);
    put_retiring({imm20, rd, `OPC_AUIPC}, rd, prog_pc + upper(imm20));
  endtask

  // release reset and check each commit up to the halt
  task automatic run_program(input logic exp_illegal);
    int idx;
    int reqs;
    idx = 0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_flag("halted in reset", 1'b0, halted);
    check_flag("illegal in reset", 1'b0, illegal);
    check_flag("cyc in reset", 1'b0, wb_cyc);
    check_flag("commit_valid in reset", 1'b0, commit_valid);
    @(posedge clk);
    rst_n <= 1'b1;
    while (!halted) begin
      @(negedge clk);
      if (commit_valid) begin
        if (idx >= exp_pc.size()) begin
          fail_now("commit seen after the last retiring instruction");
        end
        check_word("commit_pc", exp_pc[idx], commit_pc);
        check_reg("commit_rd", exp_rd[idx], commit_rd);
        check_word("commit_wdata", exp_val[idx], commit_wdata);
        idx = idx + 1;
      end
    end
    if (idx != exp_pc.size()) begin
      fail_now("core halted before all instructions retired");
    end
    check_flag("illegal at halt", exp_illegal, illegal);
    reqs = req_count;
    // halted core must stay quiet with its flags held
    repeat (WAIT_WINDOW) begin
      @(negedge clk);
      if (commit_valid || wb_cyc || wb_stb) begin
        fail_now("halted core still commits or fetches");
      end
      check_flag("halted", 1'b1, halted);
      check_flag("illegal after halt", exp_illegal, illegal);
    end
    if (req_count != reqs) begin
      fail_now("fetch request after halt");
    end
    runs_done = runs_done + 1;
  endtask

  task automatic test_arith_chain();
    begin_run("arith_chain");
    do_addi(5'd1, 5'd0, 12'd100);
    // -7
    do_addi(5'd2, 5'd0, 12'hFF9);
    do_op(5'd3, 5'd1, 5'd2, 1'b0);
    // negative results wrap
    do_op(5'd4, 5'd2, 5'd1, 1'b1);
    do_op(5'd5, 5'd0, 5'd1, 1'b1);
    do_addi(5'd6, 5'd5, 12'h7FF);
    do_op(5'd7, 5'd4, 5'd5, 1'b0);
    do_op(5'd8, 5'd7, 5'd3, 1'b1);
    put_word(`EBREAK_WORD);
    run_program(1'b0);
  endtask

  task automatic test_upper_imm();
    begin_run("upper_imm");
    do_lui(5'd5, 20'h12345);
    // bit 31 set so the sign fills the top half
    do_lui(5'd6, 20'h80000);
    do_auipc(5'd7, 20'h00001);
    do_auipc(5'd8, 20'hFFFFF);
    do_addi(5'd9, 5'd6, 12'hFFF);
    put_word(`EBREAK_WORD);
    run_program(1'b0);
  endtask

  task automatic test_x0_reads_zero();
    begin_run("x0_reads_zero");
    do_addi(5'd0, 5'd0, 12'd77);
    do_addi(5'd1, 5'd0, 12'd5);
    do_op(5'd2, 5'd0, 5'd1, 1'b0);
    do_lui(5'd0, 20'hABCDE);
    do_op(5'd3, 5'd0, 5'd0, 1'b0);
    do_op(5'd4, 5'd1, 5'd0, 1'b0);
    put_word(`EBREAK_WORD);
    run_program(1'b0);
  endtask

  task automatic test_ebreak_halts();
    begin_run("ebreak_halts");
    do_addi(5'd1, 5'd0, 12'd1);
    put_word(`EBREAK_WORD);
    // must never be fetched
    put_word(enc_i(12'd2, 5'd0, 5'd2));
    run_program(1'b0);
  endtask

  task automatic test_illegal_halts();
    begin_run("illegal_zero_word");
    do_addi(5'd1, 5'd0, 12'd9);
    put_word(32'h0000_0000);
    run_program(1'b1);
    // ecall is a system word other than ebreak
    begin_run("illegal_ecall");
    do_addi(5'd1, 5'd0, 12'd3);
    put_word(32'h0000_0073);
    run_program(1'b1);
  endtask

  initial begin
    test_arith_chain();
    test_upper_imm();
    test_x0_reads_zero();
    test_ebreak_halts();
    test_illegal_halts();
    if (runs_done == NUM_RUNS) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/cpu_top_sva.sv
`timescale 1ns/1ps

module cpu_top_sva (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     wb_cyc,
  input logic                     wb_stb,
  input logic                     wb_ack,
  input logic [cpu_pkg::XLEN-1:0] wb_adr,
  input logic                     commit_valid,
  input logic                     halted,
  input logic                     illegal
);

  // strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // request held with a steady address until ack
  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else $error("wb_adr moved or request dropped before ack");

  // a halted core retires nothing
  a_no_commit_halted: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid |-> !halted)
    else $error("commit_valid high while halted");

  a_illegal_halts: assert property (@(posedge clk) disable iff (!rst_n) illegal |-> halted)
    else $error("illegal set without halted");

endmodule

bind cpu_top cpu_top_sva i_cpu_top_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .wb_cyc       (wb_cyc),
  .wb_stb       (wb_stb),
  .wb_ack       (wb_ack),
  .wb_adr       (wb_adr),
  .commit_valid (commit_valid),
  .halted       (halted),
  .illegal      (illegal)
);

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter logic [cpu_pkg::XLEN-1:0] reset_pc = cpu_pkg::DEFAULT_RESET_PC
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // instruction bus
  input  logic                       wb_ack,
  input  logic [cpu_pkg::INST_W-1:0] wb_dat_i,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic [cpu_pkg::XLEN-1:0]   wb_adr,
  // status
  output logic                       halted,
  output logic                       illegal,
  // retirement port
  output logic                       commit_valid,
  output logic [cpu_pkg::XLEN-1:0]   commit_pc,
  output logic [cpu_pkg::REG_AW-1:0] commit_rd,
  output logic [cpu_pkg::XLEN-1:0]   commit_wdata
);

  logic [cpu_pkg::INST_W-1:0] inst;
  logic [cpu_pkg::XLEN-1:0]   pc;
  logic                       exec;
  logic [cpu_pkg::REG_AW-1:0] rs1;
  logic [cpu_pkg::REG_AW-1:0] rs2;
  logic [cpu_pkg::REG_AW-1:0] rd;
  logic [cpu_pkg::XLEN-1:0]   imm;
  cpu_pkg::alu_op_t           alu_op;
  logic                       use_imm;
  logic                       use_pc;
  logic                       reg_write;
  logic                       is_ebreak;
  logic                       is_illegal;
  logic [cpu_pkg::XLEN-1:0]   rdata_1;
  logic [cpu_pkg::XLEN-1:0]   rdata_2;
  logic [cpu_pkg::XLEN-1:0]   op_a;
  logic [cpu_pkg::XLEN-1:0]   op_b;
  logic [cpu_pkg::XLEN-1:0]   result;
  logic                       wr_en;

  pc_fetch #(
    .reset_pc (reset_pc)
  ) i_pc_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_ack     (wb_ack),
    .wb_dat_i   (wb_dat_i),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal),
    .inst       (inst),
    .pc         (pc),
    .exec       (exec),
    .halted     (halted),
    .illegal    (illegal)
  );

  decoder i_decoder (
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .reg_write  (reg_write),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  // writes land at the end of the exec cycle
  assign wr_en = exec & reg_write;

  register_file i_register_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (wr_en),
    .waddr   (rd),
    .wdata   (result),
    .raddr_1 (rs1),
    .raddr_2 (rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // operand one is pc for auipc
  assign op_a = use_pc ? pc : rdata_1;
  // operand two is the immediate for addi/lui/auipc
  assign op_b = use_imm ? imm : rdata_2;

  alu i_alu (
    .op (alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (result)
  );

  // ebreak and illegal words never retire
  assign commit_valid = wr_en;
  assign commit_pc    = pc;
  assign commit_rd    = rd;
  assign commit_wdata = result;

endmodule

// File: verilog/pc_fetch.sv
`timescale 1ns/1ps

module pc_fetch #(
  parameter logic [cpu_pkg::XLEN-1:0] reset_pc = cpu_pkg::DEFAULT_RESET_PC
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // wishbone classic read master
  input  logic                       wb_ack,
  input  logic [cpu_pkg::INST_W-1:0] wb_dat_i,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic [cpu_pkg::XLEN-1:0]   wb_adr,
  // stop causes from the decoder
  input  logic                       is_ebreak,
  input  logic                       is_illegal,
  // to the rest of the core
  output logic [cpu_pkg::INST_W-1:0] inst,
  output logic [cpu_pkg::XLEN-1:0]   pc,
  output logic                       exec,
  output logic                       halted,
  output logic                       illegal
);

  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1,
    S_STOP  = 2'd2
  } state_t;

  state_t                     state;
  logic                       req;
  logic [cpu_pkg::XLEN-1:0]   pc_q;
  logic [cpu_pkg::INST_W-1:0] inst_q;
  logic                       halted_q;
  logic                       illegal_q;
  logic                       stop_now;

  // decoder flags only matter while executing
  assign stop_now = is_ebreak | is_illegal;

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_FETCH;
      req       <= 1'b0;
      pc_q      <= reset_pc;
      halted_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      case (state)
        S_FETCH: begin
          if (!req) begin
            // first request out of reset
            req <= 1'b1;
          end else if (wb_ack) begin
            // transfer done so cyc/stb drop next cycle
            req   <= 1'b0;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (stop_now) begin
            // no writeback and no further fetch
            state     <= S_STOP;
            halted_q  <= 1'b1;
            illegal_q <= is_illegal;
          end else begin
            // retire and go straight into the next request
            state <= S_FETCH;
            req   <= 1'b1;
            pc_q  <= pc_q + cpu_pkg::XLEN'(4);
          end
        end
        S_STOP: begin
          // parked until reset
          req <= 1'b0;
        end
        default: begin
          state <= S_STOP;
          req   <= 1'b0;
        end
      endcase
    end
  end

  // instruction word captured on the ack edge
  always_ff @(posedge clk) begin
    if (state == S_FETCH && req && wb_ack) begin
      inst_q <= wb_dat_i;
    end
  end

  // cyc and stb always move together
  assign wb_cyc  = req;
  assign wb_stb  = req;
  // address is the current pc and stays steady for the whole transfer
  assign wb_adr  = pc_q;

  assign inst    = inst_q;
  assign pc      = pc_q;
  // single cycle after each ack
  assign exec    = (state == S_EXEC);
  assign halted  = halted_q;
  assign illegal = illegal_q;

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps

`include "cpu_defs.svh"

module decoder (
  input  logic [cpu_pkg::INST_W-1:0] inst,
  output logic [cpu_pkg::REG_AW-1:0] rs1,
  output logic [cpu_pkg::REG_AW-1:0] rs2,
  output logic [cpu_pkg::REG_AW-1:0] rd,
  output logic [cpu_pkg::XLEN-1:0]   imm,
  output cpu_pkg::alu_op_t           alu_op,
  output logic                       use_imm,
  output logic                       use_pc,
  output logic                       reg_write,
  output logic                       is_ebreak,
  output logic                       is_illegal
);

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [cpu_pkg::XLEN-1:0] imm_i;
  logic [cpu_pkg::XLEN-1:0] imm_u;

  // fixed field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // i-type, 12 bits sign extended
  assign imm_i = {{(cpu_pkg::XLEN-12){inst[31]}}, inst[31:20]};
  // u-type, upper 20 bits at 12, sign extended from bit 31
  assign imm_u = {{(cpu_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'h000};

  always_comb begin
    // defaults describe a non-writing instruction
    imm        = imm_i;
    alu_op     = cpu_pkg::ALU_ADD;
    use_imm    = 1'b0;
    use_pc     = 1'b0;
    reg_write  = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;

    case (opcode)
      `OPC_OP_IMM: begin
        // addi only
        if (funct3 == `F3_ADD_SUB) begin
          use_imm   = 1'b1;
          reg_write = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      `OPC_OP: begin
        if (funct3 != `F3_ADD_SUB) begin
          is_illegal = 1'b1;
        end else if (funct7 == 7'b0000000) begin
          reg_write = 1'b1;
        end else if (funct7 == `F7_SUB) begin
          alu_op    = cpu_pkg::ALU_SUB;
          reg_write = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      `OPC_LUI: begin
        // immediate straight through the alu
        imm       = imm_u;
        alu_op    = cpu_pkg::ALU_PASS_B;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      `OPC_AUIPC: begin
        // pc plus upper immediate
        imm       = imm_u;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        reg_write = 1'b1;
      end
      `OPC_SYSTEM: begin
        // ecall, csr ops etc. are not supported
        if (inst == `EBREAK_WORD) begin
          is_ebreak = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       we,
  input  logic [cpu_pkg::REG_AW-1:0] waddr,
  input  logic [cpu_pkg::XLEN-1:0]   wdata,
  input  logic [cpu_pkg::REG_AW-1:0] raddr_1,
  input  logic [cpu_pkg::REG_AW-1:0] raddr_2,
  output logic [cpu_pkg::XLEN-1:0]   rdata_1,
  output logic [cpu_pkg::XLEN-1:0]   rdata_2
);

  localparam int NUM_REGS = 2 ** cpu_pkg::REG_AW;

  logic [cpu_pkg::XLEN-1:0] regs [NUM_REGS];

  // one write port
  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read ports
  assign rdata_1 = regs[raddr_1];
  assign rdata_2 = regs[raddr_2];

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_t         op,
  input  logic [cpu_pkg::XLEN-1:0] a,
  input  logic [cpu_pkg::XLEN-1:0] b,
  output logic [cpu_pkg::XLEN-1:0] y
);

  // all results wrap modulo 2^XLEN
  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD: begin
        y = a + b;
      end
      cpu_pkg::ALU_SUB: begin
        y = a - b;
      end
      cpu_pkg::ALU_PASS_B: begin
        // lui path
        y = b;
      end
      default: begin
        // spare encoding behaves as add
        y = a + b;
      end
    endcase
  end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

  // register and address width
  localparam int XLEN = 64;

  // instruction word width
  localparam int INST_W = 32;

  // register index width, 32 registers
  localparam int REG_AW = 5;

  // boot address unless the top level overrides it
  localparam logic [XLEN-1:0] DEFAULT_RESET_PC = 64'h0000_0000_8000_0000;

  // alu operation select
  // pass-b serves lui, add serves addi/add/auipc
  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_t;

endpackage

// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// major opcodes, inst[6:0]
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_SYSTEM  7'b1110011

// funct3 shared by addi, add and sub
`define F3_ADD_SUB  3'b000

// funct7 for sub; add uses all zeros
`define F7_SUB      7'b0100000

// only system word the core accepts
`define EBREAK_WORD 32'h0010_0073

`endif
